/* Bender.yml */
package:
  name: replica_exchange

sources:
  - logic/replica_pkg.sv
  - logic/exp_approx.sv
  - logic/lfsr_rng.sv
  - logic/replica.sv
  - logic/exchange_sequencer.sv
  - logic/apb_regs.sv
  - logic/replica_exchange_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_replica_exchange.sv

/* compile.f */
+incdir+include
logic/replica_pkg.sv
logic/exp_approx.sv
logic/lfsr_rng.sv
logic/replica.sv
logic/exchange_sequencer.sv
logic/apb_regs.sv
logic/replica_exchange_top.sv
tests/tb_replica_exchange.sv

/* logic/apb_regs.sv */
`timescale 1ns/1ps

module apb_regs
    import replica_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,

    input  logic                   busy,
    input  logic [7:0]             rounds_done,
    input  replica_data_t          slot_data [replica_num],

    output logic                   start,
    output logic [7:0]             round_count,
    output logic [dbeta_w-1:0]     dbeta,
    output logic [replica_num-1:0] load_en,
    output replica_data_t          load_data
);

    logic                  access;
    logic                  wr;
    logic                  hit_ctrl;
    logic                  hit_dbeta;
    logic                  hit_status;
    logic                  hit_slot;
    logic [7:0]            slot_off;
    logic [slot_idx_w-1:0] slot_idx;
    logic                  err;
    logic                  wr_ok;

    ////////////////////////////////////////////////////////////////////////////
    // decode.
    ////////////////////////////////////////////////////////////////////////////

    assign access     = psel && penable;
    assign wr         = access && pwrite;

    assign slot_off   = paddr - reg_slot_base;
    assign slot_idx   = slot_off[2 +: slot_idx_w];

    assign hit_ctrl   = paddr == reg_ctrl;
    assign hit_dbeta  = paddr == reg_dbeta;
    assign hit_status = paddr == reg_status;
    assign hit_slot   = paddr >= reg_slot_base && slot_off < 8'(4 * replica_num)
                     && paddr[1:0] == 2'b00;

    // unmapped, busy conflict or empty run.
    always_comb begin
        err = !(hit_ctrl || hit_dbeta || hit_status || hit_slot);
        if (pwrite && busy && (hit_ctrl || hit_slot)) begin
            err = 1'b1;
        end
        if (pwrite && hit_ctrl && pwdata[7:0] == 8'd0) begin
            err = 1'b1;
        end
    end

    assign pready  = 1'b1;
    assign pslverr = access && err;
    assign wr_ok   = wr && !err;

    ////////////////////////////////////////////////////////////////////////////
    // write side.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            round_count <= '0;
            dbeta       <= '0;
        end else if (wr_ok) begin
            if (hit_ctrl) begin
                round_count <= pwdata[7:0];
            end
            if (hit_dbeta) begin
                dbeta <= pwdata[dbeta_w-1:0];
            end
        end
    end

    assign start     = wr_ok && hit_ctrl;
    assign load_data = replica_data_t'(pwdata[label_w+energy_w-1:0]);

    always_comb begin
        load_en = '0;
        if (wr_ok && hit_slot) begin
            load_en[slot_idx] = 1'b1;
        end
    end

    // read mux.
    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata[7:0] = round_count;
        end else if (hit_dbeta) begin
            prdata[dbeta_w-1:0] = dbeta;
        end else if (hit_status) begin
            prdata[15:8] = rounds_done;
            prdata[0]    = busy;
        end else if (hit_slot) begin
            prdata[label_w+energy_w-1:0] = slot_data[slot_idx];
        end
    end

    a_start_busy: assert property (@(posedge clk) disable iff (rst) start |=> busy);

endmodule

/* logic/exchange_sequencer.sv */
`timescale 1ns/1ps

module exchange_sequencer
    import replica_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       start,
    input  logic [7:0] round_count,

    output seq_ctrl_t  seq,
    output logic       busy,
    output logic [7:0] rounds_done
);

    seq_state_t state;
    phase_t     phase;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            phase       <= PH_IDLE;
            rounds_done <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state       <= LATCH;
                        phase       <= PH_EVEN;
                        rounds_done <= '0;
                    end
                end
                LATCH:  state <= WAIT1;
                WAIT1:  state <= WAIT2;
                WAIT2:  state <= DECIDE;
                DECIDE: state <= UPDATE;
                UPDATE: begin
                    rounds_done <= rounds_done + 8'd1;
                    if (rounds_done + 8'd1 == round_count) begin
                        state <= IDLE;
                        phase <= PH_IDLE;
                    end else begin
                        state <= LATCH;
                        phase <= (phase == PH_EVEN) ? PH_ODD : PH_EVEN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // strobes to the replica chain.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        seq.phase     = phase;
        seq.exp_start = state == LATCH;
        seq.decide    = state == DECIDE;
        seq.update    = state == UPDATE;
    end

    assign busy = state != IDLE;

    // register block must hold off starts during a run.
    a_start_idle: assert property (
        @(posedge clk) disable iff (rst) start |-> state == IDLE
    );

endmodule

/* logic/exp_approx.sv */
`timescale 1ns/1ps

module exp_approx
    import replica_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic                valid,
    input  logic [energy_w-1:0] gap,
    input  logic [dbeta_w-1:0]  dbeta,

    output logic                valid_out,
    output logic [rng_w-1:0]    threshold
);

    logic [energy_w+dbeta_w-1:0] prod;
    logic                        valid_d1;

    // stage 1 registers the scaled energy gap.
    always_ff @(posedge clk) begin
        if (valid) begin
            prod <= gap * dbeta;
        end
    end

    // stage 2 saturates k at 16 for a zero threshold.
    always_ff @(posedge clk) begin
        if (valid_d1) begin
            if (prod[energy_w+dbeta_w-1:exp_shift+4] != '0) begin
                threshold <= '0;
            end else begin
                threshold <= {rng_w{1'b1}} >> prod[exp_shift+3:exp_shift];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d1  <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            valid_d1  <= valid;
            valid_out <= valid_d1;
        end
    end

    // fixed two-cycle latency.
    a_latency: assert property (
        @(posedge clk) disable iff (rst) valid_out == $past(valid, 2)
    );

endmodule

/* logic/lfsr_rng.sv */
`timescale 1ns/1ps

module lfsr_rng
    import replica_pkg::*;
#(
    parameter logic [31:0] seed = rng_seed
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             step,
    output logic [rng_w-1:0] value
);

    logic [31:0] state;
    logic [31:0] x1;
    logic [31:0] x2;
    logic [31:0] x3;

    // xorshift32 with shifts 13, 17 and 5.
    assign x1 = state ^ (state << 13);
    assign x2 = x1 ^ (x1 >> 17);
    assign x3 = x2 ^ (x2 << 5);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seed;
        end else if (step) begin
            state <= x3;
        end
    end

    assign value = state[rng_w-1:0];

    a_nonzero: assert property (@(posedge clk) disable iff (rst) state != '0);

endmodule

/* logic/replica.sv */
`timescale 1ns/1ps

module replica
    import replica_pkg::*;
#(
    parameter int id = 0
) (
    input  logic               clk,
    input  logic               rst,

    input  seq_ctrl_t          seq,
    input  logic [dbeta_w-1:0] dbeta,

    input  logic               load_en,
    input  replica_data_t      load_data,

    input  replica_data_t      prev_data,
    input  replica_data_t      folw_data,
    input  logic               folw_exchange,

    output replica_data_t      out_data,
    output logic               out_exchange
);

    replica_data_t            prev_q;
    replica_data_t            folw_q;
    logic                     exp_valid;
    logic                     thr_valid;
    logic [rng_w-1:0]         threshold;
    logic [rng_w-1:0]         rng_value;
    logic signed [energy_w:0] delta;
    logic signed [energy_w:0] neg_delta;
    logic                     is_upper;
    logic                     is_lower;
    logic                     test;
    exch_cmd_t                cmd;

    // neighbour snapshot for this round.
    always_ff @(posedge clk) begin
        if (seq.exp_start) begin
            prev_q <= prev_data;
            folw_q <= folw_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_valid <= 1'b0;
        end else begin
            exp_valid <= seq.exp_start;
        end
    end

    // delta = e(i) - e(i+1) with this node as i+1.
    assign delta     = $signed({prev_q.energy[energy_w-1], prev_q.energy})
                     - $signed({out_data.energy[energy_w-1], out_data.energy});
    assign neg_delta = -delta;

    exp_approx u_exp (
        .clk       ( clk                      ),
        .rst       ( rst                      ),
        .valid     ( exp_valid                ),
        .gap       ( neg_delta[energy_w-1:0]  ),
        .dbeta     ( dbeta                    ),
        .valid_out ( thr_valid                ),
        .threshold ( threshold                )
    );

    lfsr_rng #(
        .seed ( rng_seed ^ 32'(id) )
    ) u_rng (
        .clk   ( clk           ),
        .rst   ( rst           ),
        .step  ( seq.exp_start ),
        .value ( rng_value     )
    );

    // role in the current phase.
    always_comb begin
        is_upper = 1'b0;
        is_lower = 1'b0;
        case (seq.phase)
            PH_EVEN: begin
                is_upper = (id % 2) == 1;
                is_lower = (id % 2) == 0 && id < replica_num - 1;
            end
            PH_ODD: begin
                is_upper = (id % 2) == 0 && id > 0;
                is_lower = (id % 2) == 1 && id < replica_num - 1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            test <= 1'b0;
        end else if (seq.decide) begin
            test <= is_upper && (!delta[energy_w] || rng_value < threshold);
        end
    end

    assign out_exchange = test;

    always_comb begin
        if (!seq.update) begin
            cmd = NOP;
        end else if (is_upper && test) begin
            cmd = PREV;
        end else if (is_lower && folw_exchange) begin
            cmd = FOLW;
        end else begin
            cmd = SELF;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_data <= '0;
        end else if (load_en) begin
            out_data <= load_data;
        end else begin
            case (cmd)
                PREV:    out_data <= prev_q;
                FOLW:    out_data <= folw_q;
                default: ;
            endcase
        end
    end

    a_no_load_on_update: assert property (
        @(posedge clk) disable iff (rst) seq.update |-> !load_en
    );

    // sequencer timing must line up with the exponent pipeline.
    a_thr_ready: assert property (
        @(posedge clk) disable iff (rst) seq.decide |-> thr_valid
    );

endmodule

/* logic/replica_exchange_top.sv */
`timescale 1ns/1ps

module replica_exchange_top
    import replica_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic                   start;
    logic [7:0]             round_count;
    logic [dbeta_w-1:0]     dbeta;
    logic [replica_num-1:0] load_en;
    replica_data_t          load_data;
    seq_ctrl_t              seq;
    logic                   busy;
    logic [7:0]             rounds_done;
    replica_data_t          node_data [replica_num];
    logic [replica_num-1:0] node_exchange;

    apb_regs u_regs (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .psel        ( psel        ),
        .penable     ( penable     ),
        .pwrite      ( pwrite      ),
        .paddr       ( paddr       ),
        .pwdata      ( pwdata      ),
        .prdata      ( prdata      ),
        .pready      ( pready      ),
        .pslverr     ( pslverr     ),
        .busy        ( busy        ),
        .rounds_done ( rounds_done ),
        .slot_data   ( node_data   ),
        .start       ( start       ),
        .round_count ( round_count ),
        .dbeta       ( dbeta       ),
        .load_en     ( load_en     ),
        .load_data   ( load_data   )
    );

    exchange_sequencer u_seq (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .start       ( start       ),
        .round_count ( round_count ),
        .seq         ( seq         ),
        .busy        ( busy        ),
        .rounds_done ( rounds_done )
    );

    ////////////////////////////////////////////////////////////////////////////
    // replica chain with slot 0 coldest.
    ////////////////////////////////////////////////////////////////////////////

    for (genvar n = 0; n < replica_num; n++) begin : g_node
        replica_data_t prev_data;
        replica_data_t folw_data;
        logic          folw_exchange;

        // end nodes never select the missing side.
        if (n == 0) begin : g_first
            assign prev_data = '0;
        end else begin : g_prev
            assign prev_data = node_data[n-1];
        end

        if (n == replica_num - 1) begin : g_last
            assign folw_data     = '0;
            assign folw_exchange = 1'b0;
        end else begin : g_folw
            assign folw_data     = node_data[n+1];
            assign folw_exchange = node_exchange[n+1];
        end

        replica #(
            .id ( n )
        ) u_replica (
            .clk           ( clk              ),
            .rst           ( rst              ),
            .seq           ( seq              ),
            .dbeta         ( dbeta            ),
            .load_en       ( load_en[n]       ),
            .load_data     ( load_data        ),
            .prev_data     ( prev_data        ),
            .folw_data     ( folw_data        ),
            .folw_exchange ( folw_exchange    ),
            .out_data      ( node_data[n]     ),
            .out_exchange  ( node_exchange[n] )
        );
    end

endmodule

/* logic/replica_pkg.sv */
package replica_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes.
    ////////////////////////////////////////////////////////////////////////////

    localparam int replica_num = 8;
    localparam int energy_w    = 16;
    localparam int label_w     = 8;
    localparam int dbeta_w     = 8;
    localparam int rng_w       = 16;
    localparam int slot_idx_w  = $clog2(replica_num);

    // k = (gap * dbeta) >> exp_shift.
    localparam int exp_shift   = 4;

    localparam logic [31:0] rng_seed = 32'h1f2e3d4c;

    ////////////////////////////////////////////////////////////////////////////
    // register map.
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] reg_ctrl      = 8'h00;
    localparam logic [7:0] reg_dbeta     = 8'h04;
    localparam logic [7:0] reg_status    = 8'h08;
    localparam logic [7:0] reg_slot_base = 8'h40;

    ////////////////////////////////////////////////////////////////////////////
    // types.
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [label_w-1:0]         label;
        logic signed [energy_w-1:0] energy;
    } replica_data_t;

    typedef enum logic [1:0] {
        PH_EVEN,
        PH_ODD,
        PH_IDLE
    } phase_t;

    // per-node update choice.
    typedef enum logic [1:0] {
        NOP,
        SELF,
        PREV,
        FOLW
    } exch_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        LATCH,
        WAIT1,
        WAIT2,
        DECIDE,
        UPDATE
    } seq_state_t;

    typedef struct packed {
        phase_t phase;
        logic   exp_start;
        logic   decide;
        logic   update;
    } seq_ctrl_t;

endpackage

/* include/tb_exchange_model.svh */
`ifndef TB_EXCHANGE_MODEL_SVH
`define TB_EXCHANGE_MODEL_SVH

// reference copy of the chain with slot 0 coldest.
logic [31:0] m_rng [replica_num];
logic [7:0]  m_label [replica_num];
int          m_energy [replica_num];

// xorshift32 with shifts 13, 17 and 5.
function automatic logic [31:0] xorshift_next(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// threshold for a negative delta with k = (gap * dbeta) >> 4.
function automatic int swap_threshold(input int gap, input int db);
    int k;
    k = (gap * db) >> 4;
    if (k >= 16) begin
        return 0;
    end else begin
        return 32'hffff >> k;
    end
endfunction

task automatic seed_rngs();
    for (int n = 0; n < replica_num; n++) begin
        m_rng[n] = 32'h1f2e3d4c ^ n;
    end
endtask

// every node steps its rng once per round whether used or not.
task automatic exchange_round(input logic odd, input int db);
    int         lo;
    int         delta;
    int         rnd;
    int         t_energy;
    logic [7:0] t_label;
    logic       take;
    for (int n = 0; n < replica_num; n++) begin
        m_rng[n] = xorshift_next(m_rng[n]);
    end
    for (lo = odd ? 1 : 0; lo + 1 < replica_num; lo += 2) begin
        delta = m_energy[lo] - m_energy[lo+1];
        rnd   = m_rng[lo+1][15:0];
        take  = delta >= 0 || rnd < swap_threshold(-delta, db);
        if (take) begin
            t_energy       = m_energy[lo];
            t_label        = m_label[lo];
            m_energy[lo]   = m_energy[lo+1];
            m_label[lo]    = m_label[lo+1];
            m_energy[lo+1] = t_energy;
            m_label[lo+1]  = t_label;
        end
    end
endtask

// rounds alternate starting with an even phase.
task automatic predict_run(input int rounds, input int db);
    for (int r = 0; r < rounds; r++) begin
        exchange_round(r % 2 == 1, db);
    end
endtask

`endif

/* tests/tb_replica_exchange.sv */
`timescale 1ns/1ps

module tb_replica_exchange
    import replica_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer      seed;
    logic [7:0]  ld_label [replica_num];
    logic [31:0] got [replica_num];

    `include "tb_exchange_model.svh"

    replica_exchange_top u_dut (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .psel    ( psel    ),
        .penable ( penable ),
        .pwrite  ( pwrite  ),
        .paddr   ( paddr   ),
        .pwdata  ( pwdata  ),
        .prdata  ( prdata  ),
        .pready  ( pready  ),
        .pslverr ( pslverr )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_failed(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB access sampled mid-cycle in the access phase.
    ////////////////////////////////////////////////////////////////////////////

    task automatic access_reg(input logic wr, input logic [7:0] addr,
                              input logic [31:0] data, input logic exp_err,
                              output logic [31:0] rdata);
        logic err;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        err   = pslverr;
        rdata = prdata;
        assert (pready) else stop_failed("pready was low during an access phase");
        assert (err == exp_err) else
            stop_failed($sformatf("ERR pslverr at %h got %h expected %h", addr, err, exp_err));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        access_reg(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic exp_err,
                            output logic [31:0] data);
        access_reg(1'b0, addr, 32'h0, exp_err, data);
    endtask

    task automatic wait_idle(output logic [31:0] status);
        logic done;
        done   = 1'b0;
        status = '0;
        for (int polls = 0; polls < 100 && !done; polls++) begin
            read_reg(reg_status, 1'b0, status);
            done = !status[0];
        end
        if (!done) begin
            stop_failed("timeout while waiting for the exchange run to finish");
        end
    endtask

    task automatic load_slot(input int n, input logic [7:0] label, input int energy);
        write_reg(reg_slot_base + 8'(4 * n), {8'h00, label, 16'(energy)}, 1'b0);
        ld_label[n] = label;
        m_label[n]  = label;
        m_energy[n] = $signed(16'(energy));
    endtask

    task automatic load_random(input int span);
        for (int n = 0; n < replica_num; n++) begin
            load_slot(n, 8'($random(seed)), $random(seed) % span);
        end
    endtask

    task automatic compare_slots();
        logic [31:0] data;
        logic [31:0] want;
        for (int n = 0; n < replica_num; n++) begin
            read_reg(reg_slot_base + 8'(4 * n), 1'b0, data);
            want = {8'h00, m_label[n], 16'(m_energy[n])};
            assert (data == want) else
                stop_failed($sformatf("ERR slot[%0d] got %h expected %h", n, data, want));
            got[n] = data;
        end
    endtask

    task automatic check_permutation();
        int count [256];
        for (int v = 0; v < 256; v++) begin
            count[v] = 0;
        end
        for (int n = 0; n < replica_num; n++) begin
            count[ld_label[n]]++;
            count[got[n][23:16]]--;
        end
        for (int v = 0; v < 256; v++) begin
            assert (count[v] == 0) else
                stop_failed("slot labels are not a permutation of the loaded labels");
        end
    endtask

    task automatic check_rounds(input logic [31:0] status, input int rounds);
        assert (status[15:8] == 8'(rounds)) else
            stop_failed($sformatf("ERR rounds_done got %h expected %h",
                                  status[15:8], 8'(rounds)));
    endtask

    task automatic run_rounds(input int rounds, input int db);
        logic [31:0] status;
        logic [31:0] data;
        write_reg(reg_dbeta, 32'(db), 1'b0);
        read_reg(reg_dbeta, 1'b0, data);
        assert (data == 32'(db)) else
            stop_failed($sformatf("ERR dbeta got %h expected %h", data, 32'(db)));
        write_reg(reg_ctrl, 32'(rounds), 1'b0);
        wait_idle(status);
        check_rounds(status, rounds);
        predict_run(rounds, db);
        compare_slots();
        check_permutation();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus.
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] data;
        logic [31:0] want [replica_num];
        int          rounds;
        int          db;
        int          span;
        int          e_hi;
        int          e_lo;
        logic        swap;

        seed    = 32'hbaad3c8b;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int n = 0; n < replica_num; n++) begin
            m_label[n]  = '0;
            m_energy[n] = 0;
            ld_label[n] = '0;
        end
        seed_rngs();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset state.
        read_reg(reg_status, 1'b0, data);
        assert (data == 32'h0) else
            stop_failed($sformatf("ERR status got %h expected %h", data, 32'h0));
        compare_slots();

        // slot readback and error responses.
        load_random(32768);
        compare_slots();
        write_reg(8'h0c, 32'h55, 1'b1);
        read_reg(8'h0c, 1'b1, data);
        write_reg(8'h60, 32'h00ffffff, 1'b1);
        write_reg(8'h41, 32'h00ffffff, 1'b1);
        write_reg(reg_ctrl, 32'h0, 1'b1);
        read_reg(reg_status, 1'b0, data);
        assert (data == 32'h0) else
            stop_failed($sformatf("ERR status got %h expected %h", data, 32'h0));
        read_reg(reg_ctrl, 1'b0, data);
        assert (data == 32'h0) else
            stop_failed($sformatf("ERR round_count got %h expected %h", data, 32'h0));
        compare_slots();

        // writes while a run is in flight are refused.
        db = {$random(seed)} % 256;
        write_reg(reg_dbeta, 32'(db), 1'b0);
        write_reg(reg_ctrl, 32'd6, 1'b0);
        write_reg(reg_slot_base + 8'd12, 32'h00abcdef, 1'b1);
        write_reg(reg_ctrl, 32'd5, 1'b1);
        wait_idle(data);
        check_rounds(data, 6);
        predict_run(6, db);
        compare_slots();
        check_permutation();
        read_reg(reg_ctrl, 1'b0, data);
        assert (data == 32'd6) else
            stop_failed($sformatf("ERR round_count got %h expected %h", data, 32'd6));

        // one even round where negative gaps are too large to ever swap.
        for (int p = 0; p < replica_num / 2; p++) begin
            e_hi = $random(seed) % 8000;
            swap = $random(seed);
            if (swap) begin
                e_lo = e_hi + {$random(seed)} % 600;
            end else begin
                e_lo = e_hi - 513 - {$random(seed)} % 2000;
            end
            load_slot(2 * p, 8'(8'h20 + 2 * p), e_lo);
            load_slot(2 * p + 1, 8'(8'h21 + 2 * p), e_hi);
            want[2 * p]     = {8'h00, 8'(8'h20 + 2 * p), 16'(e_lo)};
            want[2 * p + 1] = {8'h00, 8'(8'h21 + 2 * p), 16'(e_hi)};
            if (swap) begin
                want[2 * p]     = {8'h00, 8'(8'h21 + 2 * p), 16'(e_hi)};
                want[2 * p + 1] = {8'h00, 8'(8'h20 + 2 * p), 16'(e_lo)};
            end
        end
        run_rounds(1, 255);
        for (int n = 0; n < replica_num; n++) begin
            assert (got[n] == want[n]) else
                stop_failed($sformatf("ERR slot[%0d] got %h expected %h", n, got[n], want[n]));
        end

        // random runs where rng state carries over between runs.
        for (int run = 0; run < 50; run++) begin
            case (run % 3)
                0: begin
                    span = 40;
                    db   = {$random(seed)} % 4;
                end
                1: begin
                    span = 600;
                    db   = {$random(seed)} % 64;
                end
                default: begin
                    span = 32768;
                    db   = {$random(seed)} % 256;
                end
            endcase
            rounds = 1 + {$random(seed)} % 6;
            load_random(span);
            run_rounds(rounds, db);
        end

        $display("All tests passed");
        $finish;
    end

endmodule
